// File: vlog.f
+incdir+design
design/dpathPkg.sv
design/instrDecode.sv
design/regFile.sv
design/aluExec.sv
design/dpathTop.sv
dv/dpathChk.sv
dv/dpathTb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --timing --assert
TOP      = dpathTb
FLIST    = vlog.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = NO ERRORS

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/dpathTb.sv
/* Datapath testbench */
`include "dpath_consts.svh"

module dpathTb;

  import dpathPkg::*;

  localparam int DrainLimit = 8;  // Cycles allowed for results to drain

  logic               clk;
  logic               rst;
  logic               instrValid;
  instrT              instr;
  logic               resultValid;
  logic [`DATA_W-1:0] result;
  logic [`ADDR_W-1:0] resultReg;
  logic [`DATA_W-1:0] zeroDat;

  int                 errCount;
  int                 checkCount;
  int                 pushCount;
  int                 popCount;
  int                 testCount;
  int                 timeouts;
  int                 errBefore;   // Error count when the test started
  logic [31:0]        lfsr;

  dpathTop u_dut (
    .clk         (clk),
    .rst         (rst),
    .instrValid  (instrValid),
    .instr       (instr),
    .resultValid (resultValid),
    .result      (result),
    .resultReg   (resultReg),
    .zeroDat     (zeroDat)
  );

  dpathChk u_chk (
    .clk         (clk),
    .rst         (rst),
    .instrValid  (instrValid),
    .instr       (instr),
    .resultValid (resultValid),
    .result      (result),
    .resultReg   (resultReg),
    .zeroDat     (zeroDat),
    .errCount    (errCount),
    .checkCount  (checkCount),
    .pushCount   (pushCount),
    .popCount    (popCount)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  // Fibonacci LFSR on taps 32 22 2 1 stepping once per bit
  function automatic logic [15:0] takeBits(input int n);
    logic [15:0] v;
    logic        fb;
    v = '0;
    for (int k = 0; k < n; k++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[14:0], fb};
    end
    return v;
  endfunction

  function automatic logic [3:0] randNibble();
    logic [15:0] v;
    v = takeBits(4);
    return v[3:0];
  endfunction

  function automatic logic [7:0] randByte();
    logic [15:0] v;
    v = takeBits(8);
    return v[7:0];
  endfunction

  task automatic issueR(input logic [3:0] op, input logic [3:0] rd,
                        input logic [3:0] ra, input logic [3:0] rb);
    @(negedge clk);
    instrValid         = 1'b1;
    instr.rView.opcode = op;
    instr.rView.rd     = rd;
    instr.rView.ra     = ra;
    instr.rView.rb     = rb;
  endtask

  task automatic issueI(input logic [3:0] op, input logic [3:0] rd, input logic [7:0] imm);
    @(negedge clk);
    instrValid         = 1'b1;
    instr.iView.opcode = op;
    instr.iView.rd     = rd;
    instr.iView.imm8   = imm;
  endtask

  // Idle cycle with a junk word on the bus
  task automatic idle();
    @(negedge clk);
    instrValid = 1'b0;
    instr      = takeBits(16);
  endtask

  // Reads every register back through an OR with itself
  task automatic readAll();
    for (int r = 0; r < `REG_DEPTH; r++) begin
      issueR(`OP_OR, r[3:0], r[3:0], r[3:0]);
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    @(negedge clk);
    instrValid = 1'b0;
    do begin
      @(posedge clk);
      waited++;
    end while (popCount < pushCount && waited < DrainLimit);
    if (popCount < pushCount) begin
      $display("Timeout: %0d results did not appear within %0d cycles",
               pushCount - popCount, DrainLimit);
      timeouts++;
    end
  endtask

  task automatic endTest(input string name);
    drain();
    testCount++;
    $display("test %0d %s done, %0d errors", testCount, name, errCount - errBefore);
    errBefore = errCount;
  endtask

  initial begin
    int i;
    rst        = 1'b0;
    instrValid = 1'b0;
    instr      = '0;
    lfsr       = 32'hf31a3424;
    testCount  = 0;
    timeouts   = 0;
    errBefore  = 0;

    // Sixteen reset cycles with one strobe that must be ignored
    for (i = 0; i < 16; i++) begin
      @(negedge clk);
      instrValid         = (i == 5);
      instr.iView.opcode = `OP_LI;
      instr.iView.rd     = 4'h0;
      instr.iView.imm8   = 8'ha5;
      if (i == 15) begin
        rst = 1'b1;
      end
    end
    issueR(`OP_ADD, randNibble(), randNibble(), randNibble());
    issueR(`OP_ADD, 4'hf, 4'h0, 4'hf);
    endTest("reset");

    issueI(`OP_LI, 4'h1, randByte());
    issueI(`OP_LI, 4'h2, randByte());
    idle();
    issueR(`OP_ADD, 4'h3, 4'h1, 4'h2);
    issueR(`OP_SUB, 4'h4, 4'h1, 4'h2);
    issueR(`OP_SUB, 4'h5, 4'h2, 4'h1);
    issueR(`OP_AND, 4'h6, 4'h1, 4'h2);
    issueR(`OP_OR, 4'h7, 4'h1, 4'h2);
    issueR(`OP_XOR, 4'h8, 4'h1, 4'h2);
    issueI(`OP_ADDI, 4'h3, 8'hff);
    issueI(`OP_LI, 4'h9, 8'hff);
    issueR(`OP_SUB, 4'ha, 4'h0, 4'h9);   // Wraps below zero
    issueR(`OP_ADD, 4'ha, 4'ha, 4'ha);
    issueI(`OP_ADDI, 4'ha, 8'hff);
    endTest("loadArith");

    issueI(`OP_LI, 4'hb, randByte());
    for (i = 0; i < 6; i++) begin
      issueR(`OP_ADD, 4'hb, 4'hb, 4'hb);  // Same register on both ports
    end
    issueR(`OP_XOR, 4'hc, 4'hb, 4'h3);
    issueR(`OP_SUB, 4'hd, 4'hc, 4'hb);
    issueI(`OP_ADDI, 4'hd, randByte());
    issueR(`OP_OR, 4'he, 4'hd, 4'hd);
    endTest("backToBack");

    issueI(`OP_LI, 4'h0, randByte());
    idle();
    issueR(`OP_ADD, 4'h0, 4'h0, 4'h1);
    issueI(`OP_LI, 4'h5, 8'h3c);
    issueR(`OP_ADD, 4'h6, 4'h0, 4'h0);
    idle();
    idle();
    issueR(`OP_ADD, 4'h0, 4'h2, 4'h3);
    endTest("zeroMirror");

    issueR(`OP_NOP, 4'h1, 4'h2, 4'h3);
    for (i = 8; i < 16; i++) begin
      issueR(i[3:0], randNibble(), randNibble(), randNibble());
    end
    for (i = 0; i < 4; i++) begin
      idle();
    end
    readAll();
    endTest("noWrite");

    issueI(`OP_LI, 4'hf, randByte());
    issueR(`OP_ADD, 4'h0, 4'hf, 4'h0);
    for (i = 0; i < 200; i++) begin
      if (randNibble() < 4'h3) begin
        idle();
      end
      issueR(randNibble(), randNibble(), randNibble(), randNibble());
    end
    readAll();
    endTest("random");

    $display("Summary: %0d tests, %0d checks, %0d errors, %0d timeouts",
             testCount, checkCount, errCount, timeouts);
    if (errCount == 0 && timeouts == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: dv/dpathChk.sv
/* Architectural model checker */
`include "dpath_consts.svh"

module dpathChk (
  input  logic               clk,
  input  logic               rst,
  input  logic               instrValid,
  input  dpathPkg::instrT    instr,
  input  logic               resultValid,
  input  logic [`DATA_W-1:0] result,
  input  logic [`ADDR_W-1:0] resultReg,
  input  logic [`DATA_W-1:0] zeroDat,
  output int                 errCount,
  output int                 checkCount,
  output int                 pushCount,   // Results predicted
  output int                 popCount     // Result pulses seen on the outputs
);

  import dpathPkg::*;

  logic [`DATA_W-1:0] model [`REG_DEPTH];  // Registers in program order

  // Two-deep queue of expected results
  logic               s1Valid;    // In execute
  logic [`DATA_W-1:0] s1Val;
  logic [`ADDR_W-1:0] s1Reg;
  logic               s2Valid;    // Due on the outputs now
  logic [`DATA_W-1:0] s2Val;
  logic [`ADDR_W-1:0] s2Reg;

  logic [`DATA_W-1:0] zeroCommit;  // Register 0 once its write has landed
  logic               started;
  logic               hit;
  logic [`ADDR_W-1:0] dst;
  logic [`DATA_W-1:0] opA;
  logic [`DATA_W-1:0] opB;
  logic [`DATA_W-1:0] imm;
  logic [`DATA_W-1:0] val;

  initial begin
    errCount   = 0;
    checkCount = 0;
    pushCount  = 0;
    popCount   = 0;
    started    = 1'b0;
    s1Valid    = 1'b0;
    s2Valid    = 1'b0;
    zeroCommit = '0;
  end

  // Predict each strobed word at the edge that registers it
  always @(posedge clk) begin
    started = 1'b1;
    if (!rst) begin
      for (int i = 0; i < `REG_DEPTH; i++) begin
        model[i] = '0;
      end
      s1Valid    = 1'b0;
      s2Valid    = 1'b0;
      zeroCommit = '0;
    end else begin
      s2Valid = s1Valid;  // The stage 1 write lands at this edge
      s2Val   = s1Val;
      s2Reg   = s1Reg;
      if (s1Valid && s1Reg == '0) begin
        zeroCommit = s1Val;
      end
      s1Valid = 1'b0;
      if (instrValid) begin
        dst = instr.iView.rd;
        opA = model[instr.rView.ra];
        opB = model[instr.rView.rb];
        imm = {{(`DATA_W - `IMM_W){1'b0}}, instr.iView.imm8};
        hit = 1'b1;
        case (instr.rView.opcode)
          `OP_ADD:  val = opA + opB;
          `OP_SUB:  val = opA - opB;
          `OP_AND:  val = opA & opB;
          `OP_OR:   val = opA | opB;
          `OP_XOR:  val = opA ^ opB;
          `OP_LI:   val = imm;
          `OP_ADDI: val = model[dst] + imm;
          default: begin
            hit = 1'b0;  // NOP and unused codes
            val = '0;
          end
        endcase
        if (hit) begin
          model[dst] = val;
          s1Valid    = 1'b1;
          s1Val      = val;
          s1Reg      = dst;
          pushCount++;
        end
      end
    end
  end

  // Outputs are stable mid-cycle
  always @(negedge clk) begin
    if (started) begin
      checkCount++;
      assert (resultValid === s2Valid) else begin
        $display("FAIL %0t: resultValid is %b, expected %b", $time, resultValid, s2Valid);
        errCount++;
      end
      checkCount++;
      assert (zeroDat === zeroCommit) else begin
        $display("FAIL %0t: zeroDat is %h, expected %h", $time, zeroDat, zeroCommit);
        errCount++;
      end
      if (s2Valid) begin
        checkCount++;
        assert (result === s2Val) else begin
          $display("FAIL %0t: result is %h, expected %h", $time, result, s2Val);
          errCount++;
        end
        checkCount++;
        assert (resultReg === s2Reg) else begin
          $display("FAIL %0t: resultReg is %0d, expected %0d", $time, resultReg, s2Reg);
          errCount++;
        end
      end
      if (resultValid === 1'b1) begin
        popCount++;
      end
    end
  end

endmodule

// File: design/dpathTop.sv
/* Register file datapath top */
`include "dpath_consts.svh"

module dpathTop (
  input  logic               clk,
  input  logic               rst,
  input  logic               instrValid,
  input  dpathPkg::instrT    instr,
  output logic               resultValid,
  output logic [`DATA_W-1:0] result,
  output logic [`ADDR_W-1:0] resultReg,
  output logic [`DATA_W-1:0] zeroDat
);

  import dpathPkg::*;

  // Decode to execute
  logic               exValid;
  opcodeT             exOp;
  logic [`ADDR_W-1:0] exRd;
  logic [`ADDR_W-1:0] exRa;
  logic [`ADDR_W-1:0] exRb;
  logic [`IMM_W-1:0]  exImm;

  // Register file traffic
  logic [`DATA_W-1:0] adat;
  logic [`DATA_W-1:0] bdat;
  logic               wren;
  logic [`ADDR_W-1:0] rw;
  logic [`DATA_W-1:0] wdat;

  instrDecode u_decode (
    .clk        (clk),
    .rst        (rst),
    .instrValid (instrValid),
    .instr      (instr),
    .exValid    (exValid),
    .exOp       (exOp),
    .exRd       (exRd),
    .exRa       (exRa),
    .exRb       (exRb),
    .exImm      (exImm)
  );

  regFile u_regs (
    .clk     (clk),
    .rst     (rst),
    .wren    (wren),
    .ra      (exRa),
    .rb      (exRb),
    .rw      (rw),
    .wdat    (wdat),
    .adat    (adat),
    .bdat    (bdat),
    .zeroDat (zeroDat)
  );

  aluExec u_alu (
    .clk         (clk),
    .rst         (rst),
    .exValid     (exValid),
    .exOp        (exOp),
    .exRd        (exRd),
    .exImm       (exImm),
    .adat        (adat),
    .bdat        (bdat),
    .wren        (wren),
    .rw          (rw),
    .wdat        (wdat),
    .resultValid (resultValid),
    .result      (result),
    .resultReg   (resultReg)
  );

endmodule

// File: design/aluExec.sv
/* Execute and write-back stage */
`include "dpath_consts.svh"

module aluExec (
  input  logic               clk,
  input  logic               rst,
  input  logic               exValid,
  input  dpathPkg::opcodeT   exOp,
  input  logic [`ADDR_W-1:0] exRd,
  input  logic [`IMM_W-1:0]  exImm,
  input  logic [`DATA_W-1:0] adat,       // Port A operand
  input  logic [`DATA_W-1:0] bdat,       // Port B operand
  output logic               wren,
  output logic [`ADDR_W-1:0] rw,
  output logic [`DATA_W-1:0] wdat,
  output logic               resultValid,
  output logic [`DATA_W-1:0] result,
  output logic [`ADDR_W-1:0] resultReg
);

  import dpathPkg::*;

  logic               useImm;  // B operand from immediate
  logic [`DATA_W-1:0] immExt;
  logic [`DATA_W-1:0] opB;
  logic [`DATA_W-1:0] aluOut;

  assign useImm = (exOp == opLi) || (exOp == opAddi);

  // Zero extension of imm8
  assign immExt = {{(`DATA_W - `IMM_W){1'b0}}, exImm};

  assign opB = useImm ? immExt : bdat;

  // ALU, all arithmetic wraps at 16 bits
  always_comb begin
    case (exOp)
      opAdd, opAddi: begin
        aluOut = adat + opB;
      end
      opSub: begin
        aluOut = adat - opB;
      end
      opAnd: begin
        aluOut = adat & opB;
      end
      opOr: begin
        aluOut = adat | opB;
      end
      opXor: begin
        aluOut = adat ^ opB;
      end
      opLi: begin
        aluOut = opB;  // Pass immediate
      end
      default: begin
        aluOut = '0;
      end
    endcase
  end

  // Write-back in the same cycle as the read
  assign wren = exValid;
  assign rw   = exRd;
  assign wdat = aluOut;

  // Reported result, visible the cycle after write-back
  always_ff @(posedge clk) begin
    if (!rst) begin
      resultValid <= 1'b0;
      result      <= '0;
      resultReg   <= '0;
    end else begin
      resultValid <= exValid;  // Pulse, no back-pressure
      if (exValid) begin
        result    <= aluOut;
        resultReg <= exRd;
      end
    end
  end

endmodule

// File: design/regFile.sv
/* Two-read one-write register file */
`include "dpath_consts.svh"

module regFile (
  input  logic               clk,
  input  logic               rst,
  input  logic               wren,
  input  logic [`ADDR_W-1:0] ra,       // Port A read address
  input  logic [`ADDR_W-1:0] rb,       // Port B read address
  input  logic [`ADDR_W-1:0] rw,       // Write address
  input  logic [`DATA_W-1:0] wdat,
  output logic [`DATA_W-1:0] adat,
  output logic [`DATA_W-1:0] bdat,
  output logic [`DATA_W-1:0] zeroDat   // Register 0 contents
);

  logic [`DATA_W-1:0]    regs [`REG_DEPTH];  // Current register values
  logic [`REG_DEPTH-1:0] wrSel;              // One-hot write select

  // Write address decode
  always_comb begin
    wrSel = '0;
    if (wren) begin
      wrSel[rw] = 1'b1;
    end
  end

  // One storage word per register
  for (genvar g = 0; g < `REG_DEPTH; g++) begin : gReg
    logic [`DATA_W-1:0] q;

    always_ff @(posedge clk) begin
      if (!rst) begin
        q <= '0;  // Whole file clears in reset
      end else if (wrSel[g]) begin
        q <= wdat;
      end
    end

    assign regs[g] = q;
  end

  // Asynchronous reads; a write lands at the edge and shows after it
  assign adat = regs[ra];
  assign bdat = regs[rb];

  // Register 0 is ordinary storage, mirrored out for observation
  assign zeroDat = regs[0];

endmodule

// File: design/instrDecode.sv
/* Instruction decode stage */
`include "dpath_consts.svh"

module instrDecode (
  input  logic               clk,
  input  logic               rst,
  input  logic               instrValid,  // Single-cycle strobe
  input  dpathPkg::instrT    instr,
  output logic               exValid,
  output dpathPkg::opcodeT   exOp,
  output logic [`ADDR_W-1:0] exRd,
  output logic [`ADDR_W-1:0] exRa,
  output logic [`ADDR_W-1:0] exRb,
  output logic [`IMM_W-1:0]  exImm
);

  import dpathPkg::*;

  opcodeT             op;         // Opcode of the incoming word
  logic               isIType;    // LI or ADDI
  logic               isDefined;  // Opcode produces a write
  logic [`ADDR_W-1:0] aSel;       // Port A read address
  logic [`IMM_W-1:0]  immSel;

  // Opcode sits in the same bits in both views
  assign op = opcodeT'(instr.rView.opcode);

  // Classify the opcode
  always_comb begin
    isIType   = 1'b0;
    isDefined = 1'b0;
    case (op)
      opAdd, opSub, opAnd, opOr, opXor: begin
        isDefined = 1'b1;
      end
      opLi, opAddi: begin
        isDefined = 1'b1;
        isIType   = 1'b1;
      end
      default: begin
        isDefined = 1'b0;  // NOP and unused codes
      end
    endcase
  end

  // I-type reads rd on port A so ADDI sees its own destination
  assign aSel = isIType ? instr.iView.rd : instr.rView.ra;

  // Immediate only meaningful for I-type
  assign immSel = isIType ? instr.iView.imm8 : '0;

  // Issue strobe into execute
  always_ff @(posedge clk) begin
    if (!rst) begin
      exValid <= 1'b0;
    end else begin
      exValid <= instrValid && isDefined;
    end
  end

  // Field registers, loaded every cycle and qualified by exValid
  always_ff @(posedge clk) begin
    exOp  <= op;
    exRd  <= instr.rView.rd;
    exRa  <= aSel;
    exRb  <= instr.rView.rb;
    exImm <= immSel;
  end

endmodule

// File: design/dpathPkg.sv
/* Datapath shared types */
`include "dpath_consts.svh"

package dpathPkg;

  // Codes 8 to 15 are not listed and behave as NOP
  typedef enum logic [`OP_W-1:0] {
    opNop  = `OP_NOP,
    opAdd  = `OP_ADD,
    opSub  = `OP_SUB,
    opAnd  = `OP_AND,
    opOr   = `OP_OR,
    opXor  = `OP_XOR,
    opLi   = `OP_LI,
    opAddi = `OP_ADDI
  } opcodeT;

  // Register-register layout
  typedef struct packed {
    logic [`OP_W-1:0]   opcode;
    logic [`ADDR_W-1:0] rd;
    logic [`ADDR_W-1:0] ra;
    logic [`ADDR_W-1:0] rb;
  } rViewT;

  // Register-immediate layout
  typedef struct packed {
    logic [`OP_W-1:0]   opcode;
    logic [`ADDR_W-1:0] rd;
    logic [`IMM_W-1:0]  imm8;
  } iViewT;

  // One instruction word, two readings
  typedef union packed {
    rViewT rView;
    iViewT iView;
  } instrT;

endpackage

// File: design/dpath_consts.svh
/* Datapath widths and opcodes */
`ifndef DPATH_CONSTS_SVH
`define DPATH_CONSTS_SVH

// Word and register file sizes
`define DATA_W     16   // Data and instruction width
`define ADDR_W     4    // Register address
`define REG_DEPTH  16
`define OP_W       4    // Opcode field
`define IMM_W      8    // I-type immediate field

// Opcode encodings, instruction bits [15:12]
`define OP_NOP   4'h0
`define OP_ADD   4'h1
`define OP_SUB   4'h2
`define OP_AND   4'h3
`define OP_OR    4'h4
`define OP_XOR   4'h5
`define OP_LI    4'h6   // Load zero-extended imm8
`define OP_ADDI  4'h7   // rd + zero-extended imm8

`endif
